/* files.f */
+incdir+.
nnDataPkg.sv
hostLinkPkg.sv
inputGather.sv
neuronNode.sv
resultDrain.sv
denseLayer.sv
tbClock.sv
tbDenseLayer.sv

/* Makefile */
VERILATOR = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP = tbDenseLayer
FILE_LIST = files.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Simulation exit status is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tbDenseLayer.sv */
`timescale 1ns/10ps
`include "layer_settings.svh"

module tbDenseLayer
	import nnDataPkg::*;
	import hostLinkPkg::*;
();
	// Host words per test and the cycle bound for each word
	localparam int singleWords = 4 * 16 + 15;
	localparam int reluWords = 4 * 16 + 15;
	localparam int backWords = 4 * 15;
	localparam int randomWords = 4 * 16 + 20 * 15;
	localparam int reloadWords = 3 * 15 + 4 * 16 + 2;
	localparam int totalWords = singleWords + reluWords + backWords
		+ randomWords + reloadWords;
	localparam int wordBound = 40;
	localparam int timeoutCycles = totalWords * wordBound + 500;

	logic clk;
	logic reset;
	logic [31:0] inWord;
	logic inValid;
	logic inCredit;
	activation_t outResult;
	neuronIndex_t outNeuron;
	logic outLast;
	logic outValid;
	logic outCredit;

	activation_t refCoef [`NUM_NEURONS][`COEF_SLOTS];
	logic [20:0] expQ [$];    // {last, neuron, result}
	logic [20:0] gotQ [$];
	activation_t lastResults [`NUM_NEURONS];
	logic [31:0] lfsr = 32'he754bb94;
	int wordsSent = 0;
	int creditsBack = 0;
	int creditsGranted = 0;
	int resultsSeen = 0;
	int grantsLeft = 0;

	tbClock u_tbClock (.clk(clk), .reset(reset));

	denseLayer u_denseLayer (
		.clk(clk),
		.reset(reset),
		.inWord(inWord),
		.inValid(inValid),
		.inCredit(inCredit),
		.outResult(outResult),
		.outNeuron(outNeuron),
		.outLast(outLast),
		.outValid(outValid),
		.outCredit(outCredit)
	);

	task automatic checkValue(
		input string name,
		input logic [31:0] got,
		input logic [31:0] expected
	);
		if (got !== expected)
		begin
			$display("ERR %s: got %h, expected %h", name, got, expected);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] randomBits(input int width);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < width; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic activation_t modelResult(
		input int n,
		input activation_t [`NUM_INPUTS-1:0] acts
	);
		logic [31:0] product;
		activation_t sum;
		sum = refCoef[n][`NUM_INPUTS];
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			product = 32'(acts[i]) * 32'(refCoef[n][i]);
			sum = sum + product[15:0];    // Truncated product, wrapping sum
		end
		return sum[15] ? 16'h0000 : sum;
	endfunction

	always @(negedge clk)
	begin
		if (!reset && inCredit)
		begin
			creditsBack++;
			if (creditsBack > wordsSent)
				checkValue("inCredit count", creditsBack, wordsSent);
		end
		if (!reset && outValid)
		begin
			gotQ.push_back({outLast, outNeuron, outResult});
			resultsSeen++;
		end
	end

	// Sink never holds out more than OUT_CREDITS
	initial
	begin
		outCredit = 1'b0;
		forever
		begin
			@(negedge clk);
			outCredit = 1'b0;
			if (!reset && grantsLeft > 0 && creditsGranted - resultsSeen < `OUT_CREDITS)
			begin
				outCredit = 1'b1;
				grantsLeft--;
				creditsGranted++;
			end
		end
	end

	task automatic grantCredits(input int n);
		grantsLeft += n;
	endtask

	task automatic sendWord(input logic [31:0] word);
		while (wordsSent - creditsBack >= `HOST_CREDITS)
			@(negedge clk);
		inWord = word;
		inValid = 1'b1;
		wordsSent++;
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic writeCoef(input int n, input int slot, input activation_t value);
		hostWord_u w;
		w = '0;
		w.coef.kind = KIND_COEF;
		w.coef.neuron = 4'(n);
		w.coef.slot = 4'(slot);
		w.coef.value = value;
		sendWord(w);
		refCoef[n][slot] = value;
	endtask

	task automatic loadCoefs(input int n, input int base, input int step, input activation_t bias);
		for (int i = 0; i < `NUM_INPUTS; i++)
			writeCoef(n, i, 16'(base + step * i));
		writeCoef(n, `NUM_INPUTS, bias);
	endtask

	task automatic sendVector(input activation_t [`NUM_INPUTS-1:0] acts);
		hostWord_u w;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			w = '0;
			w.sample.kind = KIND_SAMPLE;
			w.sample.act = acts[i];
			sendWord(w);
		end
		for (int n = 0; n < `NUM_NEURONS; n++)
			expQ.push_back({n == `NUM_NEURONS - 1, 4'(n), modelResult(n, acts)});
	endtask

	task automatic checkResults();
		logic [20:0] got;
		logic [20:0] expected;
		while (gotQ.size() < expQ.size())
			@(negedge clk);
		while (expQ.size() > 0)
		begin
			got = gotQ.pop_front();
			expected = expQ.pop_front();
			checkValue("outNeuron", got[19:16], expected[19:16]);
			checkValue("outLast", got[20], expected[20]);
			checkValue("outResult", got[15:0], expected[15:0]);
			lastResults[got[19:16]] = got[15:0];
		end
	endtask

	task automatic resetState();
		grantCredits(3);
		repeat (30)
			@(negedge clk);
		checkValue("outValid count", gotQ.size(), 0);
	endtask

	task automatic singleVector();
		activation_t [`NUM_INPUTS-1:0] acts;
		for (int n = 0; n < `NUM_NEURONS; n++)
			loadCoefs(n, n + 1, 2, 16'(16'h0040 * n));
		for (int i = 0; i < `NUM_INPUTS; i++)
			acts[i] = 16'(3 * i + 1);
		sendVector(acts);
		grantCredits(1);    // Three still held from the reset test
		checkResults();
	endtask

	task automatic reluAndWrap();
		activation_t [`NUM_INPUTS-1:0] acts;
		loadCoefs(0, 16'hFFFF, 0, 16'h0000);
		loadCoefs(1, 16'h0900, 0, 16'h0100);
		loadCoefs(2, 16'h7FFF, 0, 16'h0000);
		loadCoefs(3, 16'h0800, 0, 16'h8000);
		for (int i = 0; i < `NUM_INPUTS; i++)
			acts[i] = 16'(i + 1);
		grantCredits(`NUM_NEURONS);
		sendVector(acts);
		checkResults();
		checkValue("outResult neuron 0", lastResults[0], 16'h0000);    // Sum 0xFF88
		checkValue("outResult neuron 1", lastResults[1], 16'h3900);    // 0x43900 wrapped
		checkValue("outResult neuron 2", lastResults[2], 16'h0000);
		checkValue("outResult neuron 3", lastResults[3], 16'h4000);
	endtask

	task automatic backPressure();
		activation_t [`NUM_INPUTS-1:0] vecs [4];
		checkValue("sink credits held", creditsGranted - resultsSeen + grantsLeft, 0);
		checkValue("words unacknowledged", wordsSent - creditsBack, 0);
		for (int v = 0; v < 4; v++)
			for (int i = 0; i < `NUM_INPUTS; i++)
				vecs[v][i] = 16'(100 * v + 7 * i);
		fork
			begin
				for (int v = 0; v < 4; v++)
					sendVector(vecs[v]);
			end
			begin
				// Third vector waits in the gatherer, fourth fills the skid FIFO
				while (wordsSent - creditsBack < `HOST_CREDITS)
					@(negedge clk);
				repeat (20)
					@(negedge clk);
				checkValue("words unacknowledged", wordsSent - creditsBack, `HOST_CREDITS);
				checkValue("outValid count", gotQ.size(), 0);
				grantCredits(4 * `NUM_NEURONS);
			end
		join
		checkResults();
	endtask

	task automatic randomVectors();
		activation_t [`NUM_INPUTS-1:0] acts;
		for (int n = 0; n < `NUM_NEURONS; n++)
			for (int s = 0; s < `COEF_SLOTS; s++)
				writeCoef(n, s, 16'(randomBits(16)));
		grantCredits(20 * `NUM_NEURONS);
		for (int v = 0; v < 20; v++)
		begin
			for (int i = 0; i < `NUM_INPUTS; i++)
				acts[i] = 16'(randomBits(16));
			sendVector(acts);
		end
		checkResults();
	endtask

	task automatic coefReload();
		activation_t [`NUM_INPUTS-1:0] acts;
		for (int i = 0; i < `NUM_INPUTS; i++)
			acts[i] = 16'(5 * i + 2);
		grantCredits(3 * `NUM_NEURONS);
		sendVector(acts);
		for (int n = 0; n < `NUM_NEURONS; n++)
			loadCoefs(n, 5 * n + 3, n, 16'h0100);
		sendVector(acts);
		writeCoef(2, `NUM_INPUTS, 16'h1234);
		writeCoef(0, 3, 16'hFFF0);
		sendVector(acts);
		checkResults();
	endtask

	initial
	begin
		repeat (timeoutCycles)
			@(posedge clk);
		$display("Timeout: the DUT stopped answering before the tests finished");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		inWord = '0;
		inValid = 1'b0;
		for (int n = 0; n < `NUM_NEURONS; n++)
			for (int s = 0; s < `COEF_SLOTS; s++)
				refCoef[n][s] = '0;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		resetState();
		singleVector();
		reluAndWrap();
		backPressure();
		randomVectors();
		coefReload();
		repeat (20)
			@(negedge clk);
		checkValue("extra outValid count", gotQ.size(), 0);
		$display("All tests passed");
		$finish;
	end

endmodule

/* tbClock.sv */
`timescale 1ns/10ps

module tbClock #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 4
)
(
	output logic clk,
	output logic reset
);
	initial
	begin
		clk = 1'b0;
		forever
			#(halfPeriod) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (resetCycles)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* denseLayer.sv */
`timescale 1ns/10ps
`include "layer_settings.svh"

module denseLayer
	import nnDataPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [31:0] inWord,    // Host word, decoded in the gatherer
	input logic inValid,
	output logic inCredit,
	output activation_t outResult,
	output neuronIndex_t outNeuron,
	output logic outLast,
	output logic outValid,
	input logic outCredit
);
	logic [`NUM_NEURONS-1:0] coefWrite;
	coefIndex_t coefIndex;
	activation_t coefValue;
	activation_t [`NUM_INPUTS-1:0] vecActs;
	logic vecValid;
	activation_t [`NUM_NEURONS-1:0] nodeResult;
	logic [`NUM_NEURONS-1:0] nodeValid;
	logic vectorFreed;

	inputGather u_inputGather (
		.clk(clk),
		.reset(reset),
		.inWord(inWord),
		.inValid(inValid),
		.vectorFreed(vectorFreed),
		.inCredit(inCredit),
		.coefWrite(coefWrite),
		.coefIndex(coefIndex),
		.coefValue(coefValue),
		.vecActs(vecActs),
		.vecValid(vecValid)
	);

	for (genvar n = 0; n < `NUM_NEURONS; n++)
	begin : gNeuron
		neuronNode u_neuronNode (
			.clk(clk),
			.reset(reset),
			.coefWrite(coefWrite[n]),
			.coefIndex(coefIndex),
			.coefValue(coefValue),
			.vecActs(vecActs),
			.vecValid(vecValid),
			.nodeResult(nodeResult[n]),
			.nodeValid(nodeValid[n])
		);
	end

	resultDrain u_resultDrain (
		.clk(clk),
		.reset(reset),
		.nodeResult(nodeResult),
		.nodeValid(nodeValid),
		.outCredit(outCredit),
		.outResult(outResult),
		.outNeuron(outNeuron),
		.outLast(outLast),
		.outValid(outValid),
		.vectorFreed(vectorFreed)
	);

endmodule

/* resultDrain.sv */
`timescale 1ns/10ps
`include "layer_settings.svh"

module resultDrain
	import nnDataPkg::*;
(
	input logic clk,
	input logic reset,
	input activation_t [`NUM_NEURONS-1:0] nodeResult,
	input logic [`NUM_NEURONS-1:0] nodeValid,
	input logic outCredit,
	output activation_t outResult,
	output neuronIndex_t outNeuron,
	output logic outLast,
	output logic outValid,
	output logic vectorFreed
);
	localparam int slotPtrWidth = $clog2(`VECTOR_SLOTS);
	localparam int slotCntWidth = $clog2(`VECTOR_SLOTS + 1);
	localparam int creditWidth = $clog2(`OUT_CREDITS + 1);

	activation_t [`NUM_NEURONS-1:0] vecMem [`VECTOR_SLOTS];
	logic [slotPtrWidth-1:0] wrSlot;
	logic [slotPtrWidth-1:0] rdSlot;
	logic [slotCntWidth-1:0] slotCount;
	logic [creditWidth-1:0] credits;
	neuronIndex_t neuronCount;     // Next neuron to send from the head vector
	logic storeVector;
	logic sendResult;
	logic lastResult;
	logic popVector;

	function automatic logic [slotPtrWidth-1:0] bumpSlot(input logic [slotPtrWidth-1:0] slot);
		if (slot == slotPtrWidth'(`VECTOR_SLOTS - 1))
			return '0;
		return slot + 1'b1;
	endfunction

	assign storeVector = nodeValid[0];    // Neurons run in lockstep
	assign sendResult = slotCount != '0 && credits != '0;
	assign lastResult = neuronCount == neuronIndex_t'(`NUM_NEURONS - 1);
	assign popVector = sendResult && lastResult;

	always_ff @(posedge clk)
	begin
		if (storeVector)
			vecMem[wrSlot] <= nodeResult;
		if (sendResult)
		begin
			outResult <= vecMem[rdSlot][neuronCount];
			outNeuron <= neuronCount;
			outLast <= lastResult;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrSlot <= '0;
			rdSlot <= '0;
			slotCount <= '0;
			credits <= '0;
			neuronCount <= '0;
			outValid <= 1'b0;
			vectorFreed <= 1'b0;
		end
		else
		begin
			if (storeVector)
				wrSlot <= bumpSlot(wrSlot);
			if (popVector)
				rdSlot <= bumpSlot(rdSlot);
			slotCount <= slotCount + slotCntWidth'(storeVector) - slotCntWidth'(popVector);
			credits <= credits + creditWidth'(outCredit) - creditWidth'(sendResult);
			if (popVector)
				neuronCount <= '0;
			else if (sendResult)
				neuronCount <= neuronCount + 1'b1;
			outValid <= sendResult;
			// Slot is free once its last result is out
			vectorFreed <= popVector;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		storeVector |-> slotCount < slotCntWidth'(`VECTOR_SLOTS))
		else $error("resultDrain: vector arrived with no free slot");

	assert property (@(posedge clk) disable iff (reset)
		(&nodeValid) == (|nodeValid))
		else $error("resultDrain: neuron valids out of step");

endmodule

/* neuronNode.sv */
`timescale 1ns/10ps
`include "layer_settings.svh"

module neuronNode
	import nnDataPkg::*;
(
	input logic clk,
	input logic reset,
	input logic coefWrite,
	input coefIndex_t coefIndex,
	input activation_t coefValue,
	input activation_t [`NUM_INPUTS-1:0] vecActs,
	input logic vecValid,
	output activation_t nodeResult,
	output logic nodeValid
);
	activation_t coefs [`COEF_SLOTS];
	activation_t [`NUM_INPUTS-1:0] actReg;
	activation_t sumNext;
	activation_t sumReg;
	logic actValid;
	logic sumValid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `COEF_SLOTS; i++)
				coefs[i] <= '0;
		end
		else if (coefWrite)
			coefs[coefIndex] <= coefValue;
	end

	// Products and sum wrap at 16 bits
	always_comb
	begin
		activation_t product;
		sumNext = coefs[`NUM_INPUTS];    // Bias
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			product = actReg[i] * coefs[i];
			sumNext = sumNext + product;
		end
	end

	always_ff @(posedge clk)
	begin
		if (vecValid)
			actReg <= vecActs;
		if (actValid)
			sumReg <= sumNext;
		if (sumValid)
			nodeResult <= sumReg[15] ? '0 : sumReg;    // ReLU
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actValid <= 1'b0;
			sumValid <= 1'b0;
			nodeValid <= 1'b0;
		end
		else
		begin
			actValid <= vecValid;
			sumValid <= actValid;
			nodeValid <= sumValid;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		coefWrite |-> !(actValid || sumValid || nodeValid))
		else $error("neuronNode: coefficient written under a live vector");

endmodule

/* inputGather.sv */
`timescale 1ns/10ps
`include "layer_settings.svh"

module inputGather
	import nnDataPkg::*;
	import hostLinkPkg::*;
(
	input logic clk,
	input logic reset,
	input hostWord_u inWord,
	input logic inValid,
	input logic vectorFreed,
	output logic inCredit,
	output logic [`NUM_NEURONS-1:0] coefWrite,
	output coefIndex_t coefIndex,
	output activation_t coefValue,
	output activation_t [`NUM_INPUTS-1:0] vecActs,
	output logic vecValid
);
	localparam int ptrWidth = $clog2(`HOST_CREDITS);
	localparam int cntWidth = $clog2(`HOST_CREDITS + 1);
	localparam int creditWidth = $clog2(`VECTOR_SLOTS + 1);
	localparam int sampleWidth = $clog2(`NUM_INPUTS + 1);

	hostWord_u fifoMem [`HOST_CREDITS];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] fifoCount;
	logic [creditWidth-1:0] vecCredits;
	logic [sampleWidth-1:0] sampleCount;
	hostWord_u headWord;
	logic vectorFull;    // All samples held, waiting for a vector credit
	logic creditsHome;
	logic popSample;
	logic popCoef;
	logic lastSample;
	logic sendVector;

	function automatic logic [ptrWidth-1:0] bumpPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(`HOST_CREDITS - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign headWord = fifoMem[rdPtr];
	assign vectorFull = sampleCount == sampleWidth'(`NUM_INPUTS);
	assign creditsHome = vecCredits == creditWidth'(`VECTOR_SLOTS);

	// Coefficients only change while no vector is in flight
	assign popSample = fifoCount != '0 && headWord.sample.kind == KIND_SAMPLE && !vectorFull;
	assign popCoef = fifoCount != '0 && headWord.coef.kind == KIND_COEF && creditsHome;
	assign lastSample = popSample && sampleCount == sampleWidth'(`NUM_INPUTS - 1);
	assign sendVector = (vectorFull || lastSample) && vecCredits != '0;

	always_ff @(posedge clk)
	begin
		if (inValid)
			fifoMem[wrPtr] <= inWord;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
			inCredit <= 1'b0;
		end
		else
		begin
			if (inValid)
				wrPtr <= bumpPtr(wrPtr);
			if (popSample || popCoef)
				rdPtr <= bumpPtr(rdPtr);
			fifoCount <= fifoCount + cntWidth'(inValid) - cntWidth'(popSample || popCoef);
			inCredit <= popSample || popCoef;    // One credit back per popped word
		end
	end

	always_ff @(posedge clk)
	begin
		if (popSample)
			vecActs[sampleCount] <= headWord.sample.act;
		if (popCoef)
		begin
			coefIndex <= headWord.coef.slot;
			coefValue <= headWord.coef.value;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sampleCount <= '0;
			vecCredits <= creditWidth'(`VECTOR_SLOTS);
			vecValid <= 1'b0;
			coefWrite <= '0;
		end
		else
		begin
			vecValid <= sendVector;
			vecCredits <= vecCredits - creditWidth'(sendVector) + creditWidth'(vectorFreed);
			if (sendVector)
				sampleCount <= '0;
			else if (popSample)
				sampleCount <= sampleCount + 1'b1;
			// Out of range neuron numbers shift out and write nothing
			coefWrite <= popCoef ? (`NUM_NEURONS'(1) << headWord.coef.neuron) : '0;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		inValid |-> fifoCount < cntWidth'(`HOST_CREDITS))
		else $error("inputGather: host wrote into a full skid FIFO");

	assert property (@(posedge clk) disable iff (reset)
		vecCredits <= creditWidth'(`VECTOR_SLOTS))
		else $error("inputGather: more vector credits than drain slots");

endmodule

/* hostLinkPkg.sv */
package hostLinkPkg;

	typedef enum logic
	{
		KIND_SAMPLE = 1'b0,
		KIND_COEF = 1'b1
	} hostKind_e;

	typedef struct packed
	{
		hostKind_e kind;
		logic [14:0] unused;
		logic [15:0] act;
	} hostSample_s;

	typedef struct packed
	{
		hostKind_e kind;
		logic [6:0] unused;
		logic [3:0] neuron;
		logic [3:0] slot;     // NUM_INPUTS selects the bias
		logic [15:0] value;
	} hostCoef_s;

	// Kind bit is the MSB of both views
	typedef union packed
	{
		hostSample_s sample;
		hostCoef_s coef;
	} hostWord_u;

endpackage

/* nnDataPkg.sv */
package nnDataPkg;

	// Activation, coefficient, product and sum all share one word
	typedef logic [15:0] activation_t;

	typedef logic [3:0] coefIndex_t;

	typedef logic [3:0] neuronIndex_t;

endpackage

/* layer_settings.svh */
`ifndef LAYER_SETTINGS_SVH
`define LAYER_SETTINGS_SVH

// Layer dimensions
`define NUM_INPUTS 15
`define NUM_NEURONS 4
`define COEF_SLOTS (`NUM_INPUTS + 1)   // Last slot is the bias

// Flow control
`define HOST_CREDITS 4     // Host skid FIFO depth
`define VECTOR_SLOTS 2     // Result vectors buffered in the drain
`define OUT_CREDITS 8      // Largest grant the sink may hold out

`endif
